// ==== Bender.yml ====
package:
  name: risc_core

export_include_dirs:
  - design

sources:
  - files:
      - design/corePkg.sv
      - design/registerFile.sv
      - design/dataMemory.sv
      - design/fetchStage.sv
      - design/decodeStage.sv
      - design/executeStage.sv
      - design/riscCore.sv
  - target: test
    files:
      - verif/clockGen.sv
      - verif/coreChecker.sv
      - verif/coreTb.sv

// ==== design/coreDefines.svh ====
// core width and memory macros
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data and address width
`define XLEN 32

// architectural registers x0..x31
`define REG_COUNT 32

// data ram depth in words, indexed by addr[9:2]
`define DMEM_WORDS 256

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== design/corePkg.sv ====
// core shared types
`include "coreDefines.svh"

package corePkg;

  // one data or address word
  typedef logic [`XLEN-1:0] word_t;
  // one instruction word
  typedef logic [31:0] inst_t;
  // register index
  typedef logic [$clog2(`REG_COUNT)-1:0] regIdx_t;

  // alu function select
  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluPassB
  } aluOp_t;

  // instruction class after decode
  typedef enum logic [3:0] {
    opAlu,
    opLoad,
    opStore,
    opBranch,
    opJal,
    opJalr,
    opLui,
    opAuipc,
    opEbreak,
    opIllegal
  } opClass_t;

  // load access width and extension
  typedef enum logic [1:0] {
    memWord,
    memByteSigned,
    memByteUnsigned
  } memSize_t;

  // IF/ID pipeline register
  typedef struct packed {
    logic  valid;
    word_t pc;
    inst_t inst;
  } ifId_t;

  // ID/EX pipeline register
  typedef struct packed {
    logic     valid;
    word_t    pc;
    opClass_t opClass;
    aluOp_t   aluOp;
    memSize_t memSize;
    regIdx_t  rd;
    logic     regWrite;
    logic     useImm;
    word_t    imm;
    word_t    rs1Data;
    word_t    rs2Data;
    // invert the equality test for bne
    logic     branchNe;
  } idEx_t;

  // one retired instruction as seen from outside
  typedef struct packed {
    logic    valid;
    word_t   pc;
    logic    regWrite;
    regIdx_t rd;
    word_t   rdData;
    logic    memWrite;
    word_t   memAddr;
    word_t   memData;
    logic    illegal;
  } retire_t;

endpackage

// ==== design/dataMemory.sv ====
// data ram with load extension
`timescale 1ns/1ps
`include "coreDefines.svh"

module dataMemory (
  input  logic              clk,
  input  corePkg::word_t    addr,
  input  corePkg::word_t    writeData,
  input  logic              write,
  input  corePkg::memSize_t size,
  output corePkg::word_t    readData
);
  import corePkg::*;

  localparam int idxBits = $clog2(`DMEM_WORDS);

  word_t mem [`DMEM_WORDS];
  logic [idxBits-1:0] wordIdx;
  word_t wordData;
  logic [7:0] byteData;

  // power-up contents are zero
  initial begin
    for (int i = 0; i < `DMEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // word index from addr[9:2], upper bits wrap
  assign wordIdx = addr[idxBits+1:2];

  // full word store only
  always_ff @(posedge clk) begin
    if (write) begin
      mem[wordIdx] <= writeData;
    end
  end

  // async read, lane picked by low address bits
  assign wordData = mem[wordIdx];
  assign byteData = wordData[8*addr[1:0] +: 8];

  always_comb begin
    case (size)
      memByteSigned:   readData = {{(`XLEN-8){byteData[7]}}, byteData};
      memByteUnsigned: readData = {{(`XLEN-8){1'b0}}, byteData};
      default:         readData = wordData;
    endcase
  end

endmodule

// ==== design/decodeStage.sv ====
// instruction decode stage
`timescale 1ns/1ps

module decodeStage (
  input  logic             clk,
  input  logic             reset,
  input  corePkg::ifId_t   ifId,
  input  logic             redirect,
  input  logic             halted,
  input  logic             wbWrite,
  input  corePkg::regIdx_t wbRd,
  input  corePkg::word_t   wbData,
  output corePkg::idEx_t   idEx
);
  import corePkg::*;

  // major opcodes of the subset
  localparam logic [6:0] opcodeReg    = 7'b0110011;
  localparam logic [6:0] opcodeImm    = 7'b0010011;
  localparam logic [6:0] opcodeLoad   = 7'b0000011;
  localparam logic [6:0] opcodeStore  = 7'b0100011;
  localparam logic [6:0] opcodeBranch = 7'b1100011;
  localparam logic [6:0] opcodeJal    = 7'b1101111;
  localparam logic [6:0] opcodeJalr   = 7'b1100111;
  localparam logic [6:0] opcodeLui    = 7'b0110111;
  localparam logic [6:0] opcodeAuipc  = 7'b0010111;
  localparam logic [6:0] opcodeSystem = 7'b1110011;
  // only ebreak is accepted from the system opcode
  localparam inst_t ebreakInst = 32'h0010_0073;

  inst_t    inst;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  regIdx_t  rdIdx;
  regIdx_t  rs1Idx;
  regIdx_t  rs2Idx;
  word_t    immI;
  word_t    immS;
  word_t    immB;
  word_t    immU;
  word_t    immJ;
  opClass_t opClass;
  aluOp_t   aluOp;
  memSize_t memSize;
  logic     useImm;
  logic     branchNe;
  word_t    imm;
  logic     writesRd;
  word_t    rs1Data;
  word_t    rs2Data;

  // field split
  assign inst   = ifId.inst;
  assign opcode = inst[6:0];
  assign rdIdx  = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1Idx = inst[19:15];
  assign rs2Idx = inst[24:20];
  assign funct7 = inst[31:25];

  // sign-extended immediates per format
  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'b0};
  assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // classify opcode and function fields
  // anything not matched below stays illegal
  always_comb begin
    opClass  = opIllegal;
    aluOp    = aluAdd;
    memSize  = memWord;
    useImm   = 1'b1;
    imm      = immI;
    branchNe = 1'b0;
    case (opcode)
      opcodeReg: begin
        useImm = 1'b0;
        if (funct7 == 7'b0000000) begin
          opClass = opAlu;
          case (funct3)
            3'b000:  aluOp = aluAdd;
            3'b010:  aluOp = aluSlt;
            3'b100:  aluOp = aluXor;
            3'b110:  aluOp = aluOr;
            3'b111:  aluOp = aluAnd;
            default: opClass = opIllegal;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          opClass = opAlu;
          aluOp   = aluSub;
        end
      end
      // addi only
      opcodeImm: begin
        if (funct3 == 3'b000) begin
          opClass = opAlu;
        end
      end
      // address is rs1 + immI
      opcodeLoad: begin
        case (funct3)
          3'b010: begin
            opClass = opLoad;
            memSize = memWord;
          end
          3'b000: begin
            opClass = opLoad;
            memSize = memByteSigned;
          end
          3'b100: begin
            opClass = opLoad;
            memSize = memByteUnsigned;
          end
          default: opClass = opIllegal;
        endcase
      end
      opcodeStore: begin
        imm = immS;
        if (funct3 == 3'b010) begin
          opClass = opStore;
        end
      end
      // compare by subtraction, zero result means equal
      opcodeBranch: begin
        imm    = immB;
        useImm = 1'b0;
        aluOp  = aluSub;
        if (funct3 == 3'b000) begin
          opClass = opBranch;
        end else if (funct3 == 3'b001) begin
          opClass  = opBranch;
          branchNe = 1'b1;
        end
      end
      opcodeJal: begin
        imm     = immJ;
        opClass = opJal;
      end
      // target is rs1 + immI through the alu
      opcodeJalr: begin
        if (funct3 == 3'b000) begin
          opClass = opJalr;
        end
      end
      opcodeLui: begin
        imm     = immU;
        aluOp   = aluPassB;
        opClass = opLui;
      end
      opcodeAuipc: begin
        imm     = immU;
        opClass = opAuipc;
      end
      opcodeSystem: begin
        if (inst == ebreakInst) begin
          opClass = opEbreak;
        end
      end
      default: opClass = opIllegal;
    endcase
  end

  // classes that produce a register result
  assign writesRd = opClass inside {opAlu, opLoad, opJal, opJalr, opLui, opAuipc};

  // register file with write-first bypass from EX
  registerFile i_registerFile (
    .clk     (clk),
    .rs1     (rs1Idx),
    .rs2     (rs2Idx),
    .rs1Data (rs1Data),
    .rs2Data (rs2Data),
    .wbWrite (wbWrite),
    .wbRd    (wbRd),
    .wbData  (wbData)
  );

  // ID/EX valid bit, squashed by redirect or halt
  always_ff @(posedge clk) begin
    if (reset) begin
      idEx.valid <= 1'b0;
    end else begin
      idEx.valid <= ifId.valid && !redirect && !halted;
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    idEx.pc       <= ifId.pc;
    idEx.opClass  <= opClass;
    idEx.aluOp    <= aluOp;
    idEx.memSize  <= memSize;
    idEx.rd       <= rdIdx;
    // x0 writes are dropped here
    idEx.regWrite <= writesRd && (rdIdx != '0);
    idEx.useImm   <= useImm;
    idEx.imm      <= imm;
    idEx.rs1Data  <= rs1Data;
    idEx.rs2Data  <= rs2Data;
    idEx.branchNe <= branchNe;
  end

  // an illegal word in EX must not write the register file
  illegalNoWrite: assert property (@(posedge clk) disable iff (reset)
    idEx.valid && idEx.opClass == opIllegal |-> !wbWrite)
    else $error("illegal instruction at %h writes a register", idEx.pc);

endmodule

// ==== design/executeStage.sv ====
// execute stage with alu, branch and writeback
`timescale 1ns/1ps
`include "coreDefines.svh"

module executeStage (
  input  logic             clk,
  input  logic             reset,
  input  corePkg::idEx_t   idEx,
  output logic             redirect,
  output corePkg::word_t   redirectPc,
  output logic             wbWrite,
  output corePkg::regIdx_t wbRd,
  output corePkg::word_t   wbData,
  output logic             halted,
  output corePkg::retire_t retire
);
  import corePkg::*;

  logic  exValid;
  word_t opA;
  word_t opB;
  word_t aluResult;
  logic  sltResult;
  logic  branchTaken;
  logic  isJump;
  logic  memWrite;
  word_t memReadData;
  word_t linkPc;

  // nothing executes once halted
  assign exValid = idEx.valid && !halted;

  // operand select
  assign opA = (idEx.opClass == opAuipc) ? idEx.pc : idEx.rs1Data;
  assign opB = idEx.useImm ? idEx.imm : idEx.rs2Data;

  assign sltResult = $signed(opA) < $signed(opB);

  always_comb begin
    case (idEx.aluOp)
      aluAdd:   aluResult = opA + opB;
      aluSub:   aluResult = opA - opB;
      aluAnd:   aluResult = opA & opB;
      aluOr:    aluResult = opA | opB;
      aluXor:   aluResult = opA ^ opB;
      aluSlt:   aluResult = {{(`XLEN-1){1'b0}}, sltResult};
      aluPassB: aluResult = opB;
      default:  aluResult = opA + opB;
    endcase
  end

  // beq takes on zero difference, bne on nonzero
  assign branchTaken = (aluResult == '0) ^ idEx.branchNe;
  assign isJump      = (idEx.opClass == opJal) || (idEx.opClass == opJalr);
  assign linkPc      = idEx.pc + word_t'(4);

  // redirect squashes the two younger instructions
  assign redirect = exValid && (isJump || (idEx.opClass == opBranch && branchTaken));
  // jalr drops both low bits to keep fetch word aligned
  assign redirectPc = (idEx.opClass == opJalr) ? (aluResult & ~word_t'(3))
                                               : (idEx.pc + idEx.imm);

  // data ram, address from alu, store data from rs2
  assign memWrite = exValid && (idEx.opClass == opStore);

  dataMemory i_dataMemory (
    .clk       (clk),
    .addr      (aluResult),
    .writeData (idEx.rs2Data),
    .write     (memWrite),
    .size      (idEx.memSize),
    .readData  (memReadData)
  );

  // writeback to register file in ID
  assign wbWrite = exValid && idEx.regWrite;
  assign wbRd    = idEx.rd;
  always_comb begin
    if (idEx.opClass == opLoad) begin
      wbData = memReadData;
    end else if (isJump) begin
      wbData = linkPc;
    end else begin
      wbData = aluResult;
    end
  end

  // sticky halt on ebreak
  always_ff @(posedge clk) begin
    if (reset) begin
      halted <= 1'b0;
    end else if (exValid && idEx.opClass == opEbreak) begin
      halted <= 1'b1;
    end
  end

  // retire report
  assign retire.valid    = exValid;
  assign retire.pc       = idEx.pc;
  assign retire.regWrite = wbWrite;
  assign retire.rd       = wbRd;
  assign retire.rdData   = wbData;
  assign retire.memWrite = memWrite;
  assign retire.memAddr  = aluResult;
  assign retire.memData  = idEx.rs2Data;
  assign retire.illegal  = exValid && (idEx.opClass == opIllegal);

  // frozen core gets nothing from decode that could steer fetch
  frozenAfterHalt: assert property (@(posedge clk) disable iff (reset)
    halted |=> !idEx.valid)
    else $error("instruction at %h entered EX after halt", idEx.pc);

endmodule

// ==== design/fetchStage.sv ====
// instruction fetch stage
`timescale 1ns/1ps
`include "coreDefines.svh"

module fetchStage (
  input  logic            clk,
  input  logic            reset,
  output corePkg::word_t  fetchPc,
  input  corePkg::inst_t  fetchInst,
  input  logic            redirect,
  input  corePkg::word_t  redirectPc,
  input  logic            halted,
  output corePkg::ifId_t  ifId
);
  import corePkg::*;

  // program counter
  // redirect from EX wins over sequential fetch
  always_ff @(posedge clk) begin
    if (reset) begin
      fetchPc <= `RESET_PC;
    end else if (redirect) begin
      fetchPc <= redirectPc;
    end else if (!halted) begin
      fetchPc <= fetchPc + word_t'(4);
    end
  end

  // IF/ID valid bit
  // wrong-path fetch is dropped when EX redirects
  always_ff @(posedge clk) begin
    if (reset) begin
      ifId.valid <= 1'b0;
    end else begin
      ifId.valid <= !redirect && !halted;
    end
  end

  // IF/ID payload
  always_ff @(posedge clk) begin
    ifId.pc   <= fetchPc;
    ifId.inst <= fetchInst;
  end

  // jalr target masking in EX keeps every fetch on a word boundary
  pcAligned: assert property (@(posedge clk) disable iff (reset)
    fetchPc[1:0] == 2'b00)
    else $error("fetchPc not word aligned: %h", fetchPc);

endmodule

// ==== design/registerFile.sv ====
// integer register file
`timescale 1ns/1ps
`include "coreDefines.svh"

module registerFile (
  input  logic             clk,
  input  corePkg::regIdx_t rs1,
  input  corePkg::regIdx_t rs2,
  output corePkg::word_t   rs1Data,
  output corePkg::word_t   rs2Data,
  input  logic             wbWrite,
  input  corePkg::regIdx_t wbRd,
  input  corePkg::word_t   wbData
);
  import corePkg::*;

  word_t regs [`REG_COUNT];

  // power-up contents are zero
  initial begin
    for (int i = 0; i < `REG_COUNT; i++) begin
      regs[i] = '0;
    end
  end

  // single write port, x0 never written
  always_ff @(posedge clk) begin
    if (wbWrite && wbRd != '0) begin
      regs[wbRd] <= wbData;
    end
  end

  // read with bypass of the value being written this cycle
  always_comb begin
    if (rs1 == '0) begin
      rs1Data = '0;
    end else if (wbWrite && wbRd == rs1) begin
      rs1Data = wbData;
    end else begin
      rs1Data = regs[rs1];
    end
  end

  always_comb begin
    if (rs2 == '0) begin
      rs2Data = '0;
    end else if (wbWrite && wbRd == rs2) begin
      rs2Data = wbData;
    end else begin
      rs2Data = regs[rs2];
    end
  end

endmodule

// ==== design/riscCore.sv ====
// three-stage rv32i subset core
`timescale 1ns/1ps

module riscCore (
  input  logic             clk,
  input  logic             reset,
  output corePkg::word_t   fetchPc,
  input  corePkg::inst_t   fetchInst,
  output corePkg::retire_t retire,
  output logic             halted
);
  import corePkg::*;

  ifId_t   ifId;
  idEx_t   idEx;
  logic    redirect;
  word_t   redirectPc;
  logic    wbWrite;
  regIdx_t wbRd;
  word_t   wbData;

  fetchStage i_fetchStage (
    .clk        (clk),
    .reset      (reset),
    .fetchPc    (fetchPc),
    .fetchInst  (fetchInst),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .halted     (halted),
    .ifId       (ifId)
  );

  decodeStage i_decodeStage (
    .clk      (clk),
    .reset    (reset),
    .ifId     (ifId),
    .redirect (redirect),
    .halted   (halted),
    .wbWrite  (wbWrite),
    .wbRd     (wbRd),
    .wbData   (wbData),
    .idEx     (idEx)
  );

  executeStage i_executeStage (
    .clk        (clk),
    .reset      (reset),
    .idEx       (idEx),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .wbWrite    (wbWrite),
    .wbRd       (wbRd),
    .wbData     (wbData),
    .halted     (halted),
    .retire     (retire)
  );

endmodule

// ==== files.f ====
+incdir+design
design/corePkg.sv
design/registerFile.sv
design/dataMemory.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/riscCore.sv
verif/clockGen.sv
verif/coreChecker.sv
verif/coreTb.sv

// ==== verif/clockGen.sv ====
// testbench clock and reset
`timescale 1ns/1ps

module clockGen #(
  parameter int period      = 100,
  parameter int resetCycles = 5
) (
  output logic clk,
  output logic reset
);

  // free-running clock
  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // reset held for the first cycles, released on a rising edge
  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== verif/coreChecker.sv ====
// reference model and retire scoreboard
`timescale 1ns/1ps
`include "coreDefines.svh"

module coreChecker #(
  parameter int maxRetires = 2000
) (
  input  logic               clk,
  input  logic               reset,
  input  corePkg::word_t     fetchPc,
  input  corePkg::retire_t   retire,
  input  logic               halted,
  input  logic [255:0][31:0] progWords,
  output logic               done,
  output int                 errorTotal
);
  import corePkg::*;

  localparam int testCount  = 6;
  // cycles watched after halt for stray retires
  localparam int quietLimit = 4;

  word_t modelPc;
  word_t regs [`REG_COUNT];
  word_t dmem [`DMEM_WORDS];
  logic  modelHalted;
  logic  inReset;
  logic  clockRunning;
  int    retired;
  int    quietCycles;
  int    checks [testCount];
  int    errors [testCount];
  string testNames [testCount];

  initial begin
    done         = 1'b0;
    errorTotal   = 0;
    modelPc      = `RESET_PC;
    modelHalted  = 1'b0;
    inReset      = 1'b0;
    clockRunning = 1'b0;
    retired      = 0;
    quietCycles  = 0;
    for (int i = 0; i < `REG_COUNT; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < `DMEM_WORDS; i++) begin
      dmem[i] = '0;
    end
    for (int t = 0; t < testCount; t++) begin
      checks[t] = 0;
      errors[t] = 0;
    end
    testNames[0] = "retire order and pc";
    testNames[1] = "alu and immediates";
    testNames[2] = "loads and stores";
    testNames[3] = "control flow";
    testNames[4] = "illegal and halt";
    testNames[5] = "reset state";
  end

  // one compare, reported on mismatch
  task automatic compareValue(input int test, input string name,
                              input logic [31:0] expected, input logic [31:0] actual);
    checks[test]++;
    if (actual !== expected) begin
      errors[test]++;
      $display("[FAIL] %s expected %h actual %h (model pc %h)",
               name, expected, actual, modelPc);
    end
  endtask

  // failure that is not a value mismatch
  task automatic flagError(input int test, input string msg);
    checks[test]++;
    errors[test]++;
    $display("ERROR: %s (model pc %h)", msg, modelPc);
  endtask

  task automatic verifyResetState();
    compareValue(5, "retire.valid", 32'd0, 32'(retire.valid));
    compareValue(5, "halted", 32'd0, 32'(halted));
    compareValue(5, "fetchPc", `RESET_PC, fetchPc);
  endtask

  // per-test lines, then the totals
  task automatic reportResults();
    int totalChecks;
    int totalErrors;
    totalChecks = 0;
    totalErrors = 0;
    for (int t = 0; t < testCount; t++) begin
      $display("test %0d %-20s checks %0d errors %0d",
               t + 1, testNames[t], checks[t], errors[t]);
      totalChecks += checks[t];
      totalErrors += errors[t];
    end
    $display("retired %0d, checks %0d, errors %0d", retired, totalChecks, totalErrors);
    errorTotal = totalErrors;
    done       = 1'b1;
  endtask

  // execute one instruction from the ISA rules and compare the retire
  task automatic stepModel();
    inst_t      inst;
    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    regIdx_t    rd;
    word_t      a;
    word_t      b;
    word_t      immI;
    word_t      immS;
    word_t      immB;
    word_t      immU;
    word_t      immJ;
    word_t      addr;
    word_t      loaded;
    logic [7:0] lane;
    word_t      result;
    word_t      nextPc;
    logic       writes;
    logic       doWrite;
    logic       bad;
    logic       isStore;
    logic       isEbreak;
    int         test;

    inst   = progWords[modelPc[9:2]];
    opcode = inst[6:0];
    rd     = inst[11:7];
    f3     = inst[14:12];
    f7     = inst[31:25];
    a      = regs[inst[19:15]];
    b      = regs[inst[24:20]];
    immI   = {{20{inst[31]}}, inst[31:20]};
    immS   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    immB   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    immU   = {inst[31:12], 12'b0};
    immJ   = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    writes   = 1'b0;
    bad      = 1'b0;
    isStore  = 1'b0;
    isEbreak = 1'b0;
    result   = '0;
    addr     = '0;
    loaded   = '0;
    lane     = '0;
    nextPc   = modelPc + 32'd4;
    test     = 1;
    case (opcode)
      7'b0110011: begin
        writes = 1'b1;
        if (f7 == 7'b0100000 && f3 == 3'b000) begin
          result = a - b;
        end else if (f7 != 7'b0000000) begin
          bad = 1'b1;
        end else begin
          case (f3)
            3'b000:  result = a + b;
            3'b010:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  result = a ^ b;
            3'b110:  result = a | b;
            3'b111:  result = a & b;
            default: bad = 1'b1;
          endcase
        end
      end
      // addi
      7'b0010011: begin
        writes = 1'b1;
        result = a + immI;
        bad    = (f3 != 3'b000);
      end
      7'b0110111: begin
        writes = 1'b1;
        result = immU;
      end
      7'b0010111: begin
        writes = 1'b1;
        result = modelPc + immU;
      end
      // word index addr[9:2], byte lane addr[1:0]
      7'b0000011: begin
        test   = 2;
        writes = 1'b1;
        addr   = a + immI;
        loaded = dmem[addr[9:2]];
        lane   = 8'(loaded >> (8 * addr[1:0]));
        case (f3)
          3'b010:  result = loaded;
          3'b000:  result = {{24{lane[7]}}, lane};
          3'b100:  result = {24'b0, lane};
          default: bad = 1'b1;
        endcase
      end
      7'b0100011: begin
        test    = 2;
        isStore = 1'b1;
        addr    = a + immS;
        bad     = (f3 != 3'b010);
      end
      7'b1100011: begin
        test = 3;
        if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
          nextPc = modelPc + immB;
        end
        bad = (f3 != 3'b000 && f3 != 3'b001);
      end
      7'b1101111: begin
        test   = 3;
        writes = 1'b1;
        result = modelPc + 32'd4;
        nextPc = modelPc + immJ;
      end
      // target with both low bits cleared
      7'b1100111: begin
        test   = 3;
        writes = 1'b1;
        result = modelPc + 32'd4;
        nextPc = (a + immI) & ~32'd3;
        bad    = (f3 != 3'b000);
      end
      7'b1110011: begin
        test     = 4;
        isEbreak = (inst == 32'h0010_0073);
        bad      = !isEbreak;
      end
      default: bad = 1'b1;
    endcase

    // illegal word has no architectural effect
    if (bad) begin
      test    = 4;
      writes  = 1'b0;
      isStore = 1'b0;
      nextPc  = modelPc + 32'd4;
    end
    doWrite = writes && (rd != '0);

    compareValue(0, "retire.pc", modelPc, retire.pc);
    compareValue(test, "retire.regWrite", 32'(doWrite), 32'(retire.regWrite));
    if (doWrite) begin
      compareValue(test, "retire.rd", 32'(rd), 32'(retire.rd));
      compareValue(test, "retire.rdData", result, retire.rdData);
    end
    compareValue(test, "retire.memWrite", 32'(isStore), 32'(retire.memWrite));
    if (isStore) begin
      compareValue(test, "retire.memAddr", addr, retire.memAddr);
      compareValue(test, "retire.memData", b, retire.memData);
    end
    compareValue(test, "retire.illegal", 32'(bad), 32'(retire.illegal));

    if (doWrite) begin
      regs[rd] = result;
    end
    if (isStore) begin
      dmem[addr[9:2]] = b;
    end
    modelPc = nextPc;
    if (isEbreak) begin
      modelHalted = 1'b1;
    end
  endtask

  // skip the time-zero clock transition
  always @(posedge clk) begin
    clockRunning <= 1'b1;
  end

  // outputs are settled at the falling edge
  always @(negedge clk) begin
    if (clockRunning && !done) begin
      if (reset) begin
        inReset = 1'b1;
        verifyResetState();
      end else if (inReset) begin
        // first cycle out of reset
        inReset = 1'b0;
        verifyResetState();
      end else if (modelHalted) begin
        compareValue(4, "halted", 32'd1, 32'(halted));
        if (retire.valid) begin
          flagError(4, "an instruction retired after the core halted");
        end
        quietCycles++;
        if (quietCycles == quietLimit) begin
          reportResults();
        end
      end else if (halted) begin
        flagError(4, "halted rose although no ebreak retired");
        reportResults();
      end else if (retire.valid) begin
        stepModel();
        retired++;
        if (retired >= maxRetires) begin
          reportResults();
        end
      end
    end
  end

endmodule

// ==== verif/coreTb.sv ====
// core testbench top
`timescale 1ns/1ps

module coreTb;
  import corePkg::*;

  localparam int clockPeriod = 100;
  // watchdog budget in clock cycles
  localparam int maxCycles   = 3000;
  localparam int progDepth   = 256;
  localparam int maxRetires  = 2000;

  logic                       clk;
  logic                       reset;
  word_t                      fetchPc;
  inst_t                      fetchInst;
  retire_t                    retire;
  logic                       halted;
  logic [progDepth-1:0][31:0] progWords;
  logic [31:0]                rngState;
  logic                       checkDone;
  int                         errorTotal;

  // xorshift32 step
  function automatic logic [31:0] nextRandom();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  // instruction formats
  function automatic inst_t rTypeWord(input logic [6:0] f7, input regIdx_t rs2,
                                      input regIdx_t rs1, input logic [2:0] f3,
                                      input regIdx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic inst_t iTypeWord(input logic [11:0] imm, input regIdx_t rs1,
                                      input logic [2:0] f3, input regIdx_t rd,
                                      input logic [6:0] opcode);
    return {imm, rs1, f3, rd, opcode};
  endfunction

  // sw only
  function automatic inst_t sTypeWord(input logic [11:0] imm, input regIdx_t rs2,
                                      input regIdx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic inst_t bTypeWord(input logic [12:0] imm, input regIdx_t rs2,
                                      input regIdx_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  // jal only
  function automatic inst_t jTypeWord(input logic [20:0] imm, input regIdx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // one random subset word for program slot idx
  function automatic inst_t drawInstruction(input int idx);
    logic [31:0] r;
    logic [31:0] f;
    int          sel;
    int          hop;
    regIdx_t     rd;
    regIdx_t     rs1;
    regIdx_t     rs2;
    logic [11:0] memImm;
    logic [2:0]  aluF3;
    logic [6:0]  aluF7;
    logic [2:0]  loadF3;
    r   = nextRandom();
    f   = nextRandom();
    sel = int'(r % 40);
    // registers x0..x7 only
    rd  = regIdx_t'(f[2:0]);
    rs1 = regIdx_t'(f[5:3]);
    rs2 = regIdx_t'(f[8:6]);
    // forward hop of 1..16 words, clipped to the last slot
    hop = 1 + int'(f[13:10]);
    if (idx + hop > progDepth - 1) begin
      hop = progDepth - 1 - idx;
    end
    // half the memory accesses hit a small window off x0
    memImm = f[31:20];
    if (f[16]) begin
      rs1    = '0;
      memImm = {6'b0, f[25:20]};
    end
    aluF7 = 7'b0000000;
    case (f[11:9])
      3'd1, 3'd7: begin
        aluF3 = 3'b000;
        aluF7 = 7'b0100000;
      end
      3'd2:    aluF3 = 3'b111;
      3'd3:    aluF3 = 3'b110;
      3'd4:    aluF3 = 3'b100;
      3'd5:    aluF3 = 3'b010;
      default: aluF3 = 3'b000;
    endcase
    case (f[10:9])
      2'd1:    loadF3 = 3'b000;
      2'd2:    loadF3 = 3'b100;
      default: loadF3 = 3'b010;
    endcase
    if (sel == 0) begin
      // mul form or a custom opcode
      if (f[12]) begin
        return rTypeWord(7'b0000001, rs2, rs1, f[11:9], rd);
      end
      return {f[31:7], 7'b0001011};
    end else if (sel <= 9) begin
      return rTypeWord(aluF7, rs2, rs1, aluF3, rd);
    end else if (sel <= 20 && sel >= 18) begin
      return {f[31:12], rd, 7'b0110111};
    end else if (sel == 21) begin
      return {f[31:12], rd, 7'b0010111};
    end else if (sel >= 22 && sel <= 24 || sel == 33) begin
      return iTypeWord(memImm, rs1, loadF3, rd, 7'b0000011);
    end else if (sel >= 25 && sel <= 27) begin
      return sTypeWord(memImm, rs2, rs1);
    end else if (sel >= 28 && sel <= 30) begin
      return bTypeWord(13'(hop * 4), rs2, rs1, {2'b00, f[9]});
    end else if (sel == 31) begin
      return jTypeWord(21'(hop * 4), rd);
    end else if (sel == 32) begin
      // absolute target off x0, low bits set to exercise clearing
      return iTypeWord(12'((idx + hop) * 4 + int'(f[15:14])), '0, 3'b000, rd,
                       7'b1100111);
    end
    return iTypeWord(f[31:20], rs1, 3'b000, rd, 7'b0010011);
  endfunction

  // program image, ebreak in the last slot
  initial begin
    rngState = 32'h109c18a7;
    for (int i = 0; i < progDepth; i++) begin
      progWords[i] = drawInstruction(i);
    end
    progWords[progDepth-1] = 32'h0010_0073;
  end

  // combinational fetch port
  assign fetchInst = reset ? inst_t'(0) : progWords[fetchPc[9:2]];

  clockGen #(
    .period      (clockPeriod),
    .resetCycles (5)
  ) i_clockGen (
    .clk   (clk),
    .reset (reset)
  );

  riscCore i_riscCore (
    .clk       (clk),
    .reset     (reset),
    .fetchPc   (fetchPc),
    .fetchInst (fetchInst),
    .retire    (retire),
    .halted    (halted)
  );

  coreChecker #(
    .maxRetires (maxRetires)
  ) i_coreChecker (
    .clk        (clk),
    .reset      (reset),
    .fetchPc    (fetchPc),
    .retire     (retire),
    .halted     (halted),
    .progWords  (progWords),
    .done       (checkDone),
    .errorTotal (errorTotal)
  );

  // final verdict once the checker has reported
  initial begin
    wait (checkDone === 1'b1);
    if (errorTotal == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(maxCycles * clockPeriod);
    $display("timeout: the core neither halted nor reached %0d retires in %0d cycles",
             maxRetires, maxCycles);
    $display("*** FAILED ***");
    $finish;
  end

endmodule
